// File: testbench/controlUnit_input.txt
// instruction psr cycles fetch decode execute writeBack (hex, writeBack 0000 when skipped)
0352 00 4 0120 0100 0113 9103 // ADD r3
257A 00 4 0120 0100 0B10 9105 // ORI r5
51FF 00 4 0120 0100 0710 9101 // ADDI r1
F712 00 4 0120 0100 0310 9107 // LUI r7
04B5 00 3 0120 0100 8114 0000 // CMP
B605 00 3 0120 0100 8710 0000 // CMPI
4309 00 4 0120 0100 0150 91C3 // Load r3
4248 00 4 0120 0100 0F10 A100 // Store
4F85 00 4 0120 0100 0F10 C100 // JAL
6123 00 3 0120 0100 8110 0000 // ADDUI no-op
C010 08 4 0120 0100 0210 C100 // Bcond Eq taken
41C2 08 4 0120 0100 0F10 8100 // Jcond Ne not taken
C2F0 00 4 0120 0100 0210 8100 // Bcond Cs not taken
43C5 00 4 0120 0100 0F10 C100 // Jcond Cc taken
C404 02 4 0120 0100 0210 C100 // Bcond Hi taken
45C1 02 4 0120 0100 0F10 8100 // Jcond Ls not taken
C6FE 10 4 0120 0100 0210 C100 // Bcond Gt taken
47C3 10 4 0120 0100 0F10 8100 // Jcond Le not taken
C808 04 4 0120 0100 0210 C100 // Bcond Fs taken
49C7 1B 4 0120 0100 0F10 C100 // Jcond Fc taken
CA10 08 4 0120 0100 0210 8100 // Bcond Lo not taken
4BC4 02 4 0120 0100 0F10 C100 // Jcond Hs taken
CC20 01 4 0120 0100 0210 C100 // Bcond Lt taken
4DC6 05 4 0120 0100 0F10 8100 // Jcond Ge not taken
CE01 00 4 0120 0100 0210 C100 // Bcond Uc taken
4FC8 1F 4 0120 0100 0F10 8100 // Jcond Nj not taken

// File: controlUnit.f
design/controlPkg.sv
design/conditionEvaluator.sv
design/instructionDecoder.sv
design/phaseSequencer.sv
design/controlUnit.sv
testbench/controlUnit_props.sv
testbench/controlUnitTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -f controlUnit.f --top-module controlUnitTb -o controlUnitSim || exit 1
./obj_dir/controlUnitSim || exit 1

// File: testbench/controlUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnitTb;
    import controlPkg::*;

    localparam int vectorCount = 26;
    localparam int vectorWords = 7;  // Instruction, psr, cycles, fetch to write-back words

    logic        clock;
    logic        reset;
    instructionT instruction;
    psrT         psr;
    controlT     control;
    logic [15:0] vectors [vectorCount * vectorWords];

    controlUnit controlUnit_i (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic checkControl(input logic [15:0] expected, input int vector, input int step);
        assert (control === expected) else begin
            $display("** Error at %0t ns: vector %0d step %0d control %h expected %h",
                $time, vector, step, control, expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "Control word mismatch");
        end
    endtask

    task automatic runVector(input int vector);
        int base;
        int cycles;
        int expectedCycles;
        base = vector * vectorWords;
        expectedCycles = int'(vectors[base + 2]);
        instruction = instructionT'(vectors[base]);
        psr = psrT'(vectors[base + 1][4:0]);
        cycles = 0;
        do begin  // Next fetch ends the instruction
            #1;
            if (cycles < 4) begin
                checkControl(vectors[base + 3 + cycles], vector, cycles);
            end
            cycles++;
            @(posedge clock);
            #1;
        end while (!control.irReadEnable && cycles < 10);
        if (!control.irReadEnable) begin
            $display("No fetch phase within 10 cycles of vector %0d", vector);
            $display("Simulation finished: FAIL");
            $fatal(1, "Timeout waiting for fetch");
        end
        assert (cycles == expectedCycles) else begin
            $display("** Error at %0t ns: vector %0d took %0d cycles expected %0d",
                $time, vector, cycles, expectedCycles);
            $display("Simulation finished: FAIL");
            $fatal(1, "Cycle count mismatch");
        end
    endtask

    initial begin
        reset = 1'b0;
        instruction = '0;
        psr = '0;
        $readmemh("testbench/controlUnit_input.txt", vectors);
        repeat (4) @(posedge clock);
        #1;
        checkControl(16'h0120, -1, 0);  // Fetch word held by reset
        reset = 1'b1;
        for (int vector = 0; vector < vectorCount; vector++) begin
            runVector(vector);
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/controlUnit_props.sv
`timescale 1ns/1ps
`default_nettype none

module sequencerAssertions (
    input logic                clock,
    input logic                reset,
    input controlPkg::phaseT   phase,
    input controlPkg::controlT control
);
    import controlPkg::*;

    assert property (@(posedge clock) disable iff (!reset)
        phase == phaseFetch |=> phase == phaseDecode)
        else $error("Fetch was not followed by decode");
    assert property (@(posedge clock) disable iff (!reset)
        !(control.blockRamWriteEnable && control.registerFileWriteEnable))
        else $error("RAM write and register write enabled together");
    assert property (@(posedge clock) disable iff (!reset)
        control.pcIncrementOrWrite |-> control.pcEnable)
        else $error("PC write select without PC enable");

endmodule

bind phaseSequencer sequencerAssertions sequencerAssertions_i (.*);

`default_nettype wire

// File: design/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
    input  logic                    clock,
    input  logic                    reset,
    input  controlPkg::instructionT instruction,
    input  controlPkg::psrT         psr,
    output controlPkg::controlT     control
);
    import controlPkg::*;

    instructionPlanT plan;
    logic            taken;
    logic            isRType;

    assign isRType = instruction.major == opRType;  // Only R-type writes dest in execute

    instructionDecoder instructionDecoder_i (
        .instruction (instruction),
        .plan        (plan)
    );

    conditionEvaluator conditionEvaluator_i (
        .psr   (psr),
        .cond  (condCodeT'(instruction.dest)),
        .taken (taken)
    );

    phaseSequencer phaseSequencer_i (
        .clock   (clock),
        .reset   (reset),
        .plan    (plan),
        .taken   (taken),
        .dest    (instruction.dest),
        .isRType (isRType),
        .control (control)
    );

endmodule

`default_nettype wire

// File: design/phaseSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module phaseSequencer (
    input  logic                        clock,
    input  logic                        reset,
    input  controlPkg::instructionPlanT plan,
    input  logic                        taken,
    input  logic [3:0]                  dest,
    input  logic                        isRType,
    output controlPkg::controlT         control
);
    import controlPkg::*;

    phaseT phase;
    phaseT nextPhase;

    always_ff @(posedge clock) begin
        if (!reset) begin
            phase <= phaseFetch;
        end else begin
            phase <= nextPhase;
        end
    end

    always_comb begin
        case (phase)
            phaseFetch:     nextPhase = phaseDecode;
            phaseDecode:    nextPhase = phaseExecute;
            phaseExecute:   nextPhase = plan.skipWriteBack ? phaseFetch : phaseWriteBack;
            phaseWriteBack: nextPhase = phaseFetch;
            default:        nextPhase = phaseFetch;
        endcase
    end

    always_comb begin
        control = controlIdle;
        case (phase)
            phaseFetch: begin
                control.irReadEnable = 1'b1;
            end
            phaseDecode: begin
                control = controlIdle;
            end
            phaseExecute: begin
                control.aluEnable = 1'b1;
                control.integerTypeSelection = plan.execute.immKind;
                control.reg2OrImmediate = plan.execute.reg2OrImmediate;
                control.pcOrRegister = plan.execute.pcOrRegister;
                control.pcOrAluOutputRamRead = plan.execute.aluToRamAddress;
                control.registerWriteAddress = isRType ? dest : 4'd0;
                control.pcEnable = plan.skipWriteBack;  // Last cycle of CMP and no-ops
            end
            phaseWriteBack: begin
                control.pcEnable = 1'b1;
                control.registerFileWriteEnable = plan.writeBack.registerWrite;
                control.blockRamWriteEnable = plan.writeBack.ramWrite;
                control.writeBackFromRam = plan.writeBack.ramToRegister;
                control.pcOrAluOutputRamRead = plan.writeBack.ramToRegister;
                control.registerWriteAddress = plan.writeBack.registerWrite ? dest : 4'd0;
                case (plan.writeBack.jumpKind)
                    jumpAlways:      control.pcIncrementOrWrite = 1'b1;
                    jumpConditional: control.pcIncrementOrWrite = taken;
                    default:         control.pcIncrementOrWrite = 1'b0;
                endcase
            end
            default: begin
                control = controlIdle;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/instructionDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instructionDecoder (
    input  controlPkg::instructionT     instruction,
    output controlPkg::instructionPlanT plan
);
    import controlPkg::*;

    always_comb begin
        plan = '0;
        plan.execute.immKind = immLoad;
        plan.execute.pcOrRegister = 1'b1;
        plan.writeBack.jumpKind = jumpNone;

        case (instruction.major)
            opRType: begin
                plan.writeBack.registerWrite = instruction.ext != extCmp;
                plan.skipWriteBack = instruction.ext == extCmp;  // CMP sets flags only
            end
            opAndi, opOri, opXori, opMovi: begin
                plan.execute.reg2OrImmediate = 1'b1;
                plan.execute.immKind = immZero;
                plan.writeBack.registerWrite = 1'b1;
            end
            opAddi, opSubi: begin
                plan.execute.reg2OrImmediate = 1'b1;
                plan.execute.immKind = immSigned;
                plan.writeBack.registerWrite = 1'b1;
            end
            opCmpi: begin
                plan.execute.reg2OrImmediate = 1'b1;
                plan.execute.immKind = immSigned;
                plan.skipWriteBack = 1'b1;
            end
            opLui: begin
                plan.execute.reg2OrImmediate = 1'b1;
                plan.execute.immKind = immLoad;  // Upper byte load
                plan.writeBack.registerWrite = 1'b1;
            end
            opShift: begin
                // LSH and ASHU take the amount from a register
                plan.execute.reg2OrImmediate =
                    !(instruction.ext == 4'b0100 || instruction.ext == 4'b0110);
                plan.writeBack.registerWrite = 1'b1;
            end
            opLoadStore: begin
                case (instruction.ext)
                    extLoad: begin
                        plan.execute.aluToRamAddress = 1'b1;
                        plan.writeBack.registerWrite = 1'b1;
                        plan.writeBack.ramToRegister = 1'b1;
                    end
                    extStore: begin
                        plan.execute.reg2OrImmediate = 1'b1;
                        plan.execute.immKind = immHardZero;
                        plan.writeBack.ramWrite = 1'b1;
                    end
                    extJcond: begin
                        plan.execute.reg2OrImmediate = 1'b1;
                        plan.execute.immKind = immHardZero;  // Target comes from register
                        plan.writeBack.jumpKind = jumpConditional;
                    end
                    extJal: begin
                        plan.execute.reg2OrImmediate = 1'b1;
                        plan.execute.immKind = immHardZero;
                        plan.writeBack.jumpKind = jumpAlways;
                    end
                    default: begin
                        plan.skipWriteBack = 1'b1;
                    end
                endcase
            end
            opBcond: begin
                plan.execute.pcOrRegister = 1'b0;  // PC-relative target
                plan.execute.reg2OrImmediate = 1'b1;
                plan.execute.immKind = immLoad;
                plan.writeBack.jumpKind = jumpConditional;
            end
            default: begin
                // ADDUI, ADDCI, SUBCI and MULI behave as no-ops
                plan.skipWriteBack = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/conditionEvaluator.sv
`timescale 1ns/1ps
`default_nettype none

module conditionEvaluator (
    input  controlPkg::psrT      psr,
    input  controlPkg::condCodeT cond,
    output logic                 taken
);
    import controlPkg::*;

    always_comb begin
        case (cond)
            condEq: taken = psr.zero;
            condNe: taken = !psr.zero;
            condCs: taken = psr.carry;
            condCc: taken = !psr.carry;
            condHi: taken = psr.low;
            condLs: taken = !psr.low;
            condGt: taken = psr.negative;
            condLe: taken = !psr.negative;
            condFs: taken = psr.flag;
            condFc: taken = !psr.flag;
            condLo: begin
                taken = !psr.low && !psr.zero;
            end
            condHs: begin
                taken = psr.low || psr.zero;
            end
            condLt: begin
                taken = !psr.negative && !psr.zero;
            end
            condGe: begin
                taken = psr.zero || psr.negative;
            end
            condUc: taken = 1'b1;   // Unconditional
            condNj: taken = 1'b0;   // Never jump
            default: taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: design/controlPkg.sv
`default_nettype none

package controlPkg;

    typedef struct packed {
        logic [3:0] major;
        logic [3:0] dest;   // Condition field for Bcond and Jcond
        logic [3:0] ext;
        logic [3:0] src;
    } instructionT;

    typedef struct packed {
        logic negative;
        logic zero;
        logic flag;
        logic low;
        logic carry;
    } psrT;

    typedef enum logic [3:0] {
        condEq = 4'd0,
        condNe = 4'd1,
        condCs = 4'd2,
        condCc = 4'd3,
        condHi = 4'd4,
        condLs = 4'd5,
        condGt = 4'd6,
        condLe = 4'd7,
        condFs = 4'd8,
        condFc = 4'd9,
        condLo = 4'd10,
        condHs = 4'd11,
        condLt = 4'd12,
        condGe = 4'd13,
        condUc = 4'd14,
        condNj = 4'd15
    } condCodeT;

    typedef enum logic [1:0] {
        phaseFetch,
        phaseDecode,
        phaseExecute,
        phaseWriteBack
    } phaseT;

    typedef enum logic [1:0] {
        immLoad     = 2'd0,
        immSigned   = 2'd1,
        immZero     = 2'd2,
        immHardZero = 2'd3
    } immKindT;

    typedef enum logic [1:0] {
        jumpNone,
        jumpAlways,
        jumpConditional
    } jumpKindT;

    typedef struct packed {
        immKindT immKind;
        logic    reg2OrImmediate;
        logic    pcOrRegister;
        logic    aluToRamAddress;
    } executePlanT;

    typedef struct packed {
        logic     registerWrite;
        logic     ramWrite;
        logic     ramToRegister;
        jumpKindT jumpKind;
    } writeBackPlanT;

    typedef struct packed {
        executePlanT   execute;
        writeBackPlanT writeBack;
        logic          skipWriteBack;  // Execute returns straight to fetch
    } instructionPlanT;

    typedef struct packed {
        logic       pcEnable;
        logic       pcIncrementOrWrite;
        logic       blockRamWriteEnable;
        logic       registerFileWriteEnable;
        immKindT    integerTypeSelection;
        logic       reg2OrImmediate;
        logic       pcOrRegister;
        logic       writeBackFromRam;
        logic       pcOrAluOutputRamRead;
        logic       irReadEnable;
        logic       aluEnable;
        logic [3:0] registerWriteAddress;
    } controlT;

    localparam logic [3:0] opRType     = 4'd0;
    localparam logic [3:0] opAndi      = 4'd1;
    localparam logic [3:0] opOri       = 4'd2;
    localparam logic [3:0] opXori      = 4'd3;
    localparam logic [3:0] opLoadStore = 4'd4;
    localparam logic [3:0] opAddi      = 4'd5;
    localparam logic [3:0] opShift     = 4'd8;
    localparam logic [3:0] opSubi      = 4'd9;
    localparam logic [3:0] opCmpi      = 4'd11;
    localparam logic [3:0] opBcond     = 4'd12;
    localparam logic [3:0] opMovi      = 4'd13;
    localparam logic [3:0] opLui       = 4'd15;

    localparam logic [3:0] extCmp   = 4'd11;
    localparam logic [3:0] extLoad  = 4'd0;
    localparam logic [3:0] extStore = 4'd4;
    localparam logic [3:0] extJal   = 4'd8;
    localparam logic [3:0] extJcond = 4'd12;

    localparam controlT controlIdle = '{
        pcEnable:                1'b0,
        pcIncrementOrWrite:      1'b0,
        blockRamWriteEnable:     1'b0,
        registerFileWriteEnable: 1'b0,
        integerTypeSelection:    immLoad,
        reg2OrImmediate:         1'b0,
        pcOrRegister:            1'b1,
        writeBackFromRam:        1'b0,
        pcOrAluOutputRamRead:    1'b0,
        irReadEnable:            1'b0,
        aluEnable:               1'b0,
        registerWriteAddress:    4'd0
    };

endpackage

`default_nettype wire
